//--- rob_entry.f
source/rob_entry_pkg.sv
source/rob_create_port.sv
source/rob_cmplt_ctrl.sv
source/rob_lsu_wb_info.sv
source/rob_entry.sv
verification/rob_entry_tb.sv

//--- verification/rob_entry_tb.sv
`timescale 1ns/100ps

module rob_entry_tb;

  import rob_entry_pkg::*;

  // ==============================
  // run length and field groups
  // ==============================
  localparam int create_iters = 8;
  localparam int fold_iters   = 16;
  localparam int direct_iters = 12;
  // reset, drain gaps and the flush/pop sequence on top of the loops
  localparam int run_cycles = 20 + 2 * create_iters + 3 * fold_iters + 3 * direct_iters;
  localparam logic [rob_width-1:0] ctl_mask    = 40'h00_0000_000F;
  localparam logic [rob_width-1:0] wb_mask     = 40'h00_00E0_6000;
  localparam logic [rob_width-1:0] static_mask = 40'hFF_FF1F_9FF0;

  logic                    entry_clk;
  logic                    cpurst_b;
  logic [rob_width-1:0]    create_data [create_ports];
  logic [create_ports-1:0] create_sel;
  logic                    create_en;
  logic                    create_dp_en;
  logic                    pop_en;
  logic                    flush;
  logic [cmplt_ports-1:0]  cmplt_vld;
  lsu_wb_info_t            p3_flags;
  lsu_wb_info_t            p4_flags;
  logic [rob_width-1:0]    read_data;
  // expected record with the timing of the entry registers
  rob_entry_t              exp_rec;
  logic [31:0]             seed = 32'd88;
  string                   test_name = "reset";
  int                      err_count = 0;
  int                      test_errs = 0;
  int                      pass_count = 0;
  int                      fail_count = 0;

  rob_entry UUT (
    .entry_clk             (entry_clk),
    .cpurst_b              (cpurst_b),
    .create0_data          (create_data[0]),
    .create1_data          (create_data[1]),
    .create2_data          (create_data[2]),
    .create3_data          (create_data[3]),
    .create4_data          (create_data[4]),
    .create_sel            (create_sel),
    .create_en             (create_en),
    .create_dp_en          (create_dp_en),
    .pop_en                (pop_en),
    .flush                 (flush),
    .cmplt_vld             (cmplt_vld),
    .pipe3_bkpta_data      (p3_flags.bkpta_data),
    .pipe3_bkptb_data      (p3_flags.bkptb_data),
    .pipe3_no_spec_hit     (p3_flags.no_spec_hit),
    .pipe3_no_spec_miss    (p3_flags.no_spec_miss),
    .pipe3_no_spec_mispred (p3_flags.no_spec_mispred),
    .pipe4_bkpta_data      (p4_flags.bkpta_data),
    .pipe4_bkptb_data      (p4_flags.bkptb_data),
    .pipe4_no_spec_hit     (p4_flags.no_spec_hit),
    .pipe4_no_spec_miss    (p4_flags.no_spec_miss),
    .pipe4_no_spec_mispred (p4_flags.no_spec_mispred),
    .read_data             (read_data)
  );

  // 4 ns clock
  initial begin
    entry_clk = 1'b0;
    forever #2 entry_clk = ~entry_clk;
  end

  // lcg step whose upper bits are the useful ones
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ==============================
  // reference model
  // ==============================
  function automatic rob_entry_t next_exp(input rob_entry_t cur);
    rob_entry_t           rec;
    rob_entry_t           nxt;
    lsu_wb_info_t         merged;
    int                   n;
    logic                 direct;
    logic                 p3;
    logic                 p4;
    logic [cnt_width-1:0] base;
    rec = 'x;
    for (int i = 0; i < create_ports; i++) begin
      if (create_sel[i]) begin
        rec = create_data[i];
      end
    end
    nxt    = cur;
    n      = $countones({cmplt_vld[fold_p0], cmplt_vld[fold_p1],
                         cmplt_vld[fold_p5], cmplt_vld[fold_p6]});
    p3     = cmplt_vld[lsu_p3];
    p4     = cmplt_vld[lsu_p4];
    direct = cmplt_vld[direct_p2] | p3 | p4;
    base   = create_en ? rec.cmplt_cnt : cur.cmplt_cnt;
    merged = ({5{p3}} & p3_flags) | ({5{p4}} & p4_flags);
    // create-only fields
    if (create_dp_en) begin
      nxt = (nxt & ~static_mask) | (rec & static_mask);
    end
    // lsu write-back flags
    if (p3 || p4) begin
      nxt.bkpta_data      = merged.bkpta_data;
      nxt.bkptb_data      = merged.bkptb_data;
      nxt.no_spec_hit     = merged.no_spec_hit;
      nxt.no_spec_miss    = merged.no_spec_miss;
      nxt.no_spec_mispred = merged.no_spec_mispred;
    end else if (create_dp_en) begin
      nxt = (nxt & ~wb_mask) | (rec & wb_mask);
    end
    // valid bit
    if (flush) begin
      nxt.vld = 1'b0;
    end else if (create_en) begin
      nxt.vld = rec.vld;
    end else if (pop_en) begin
      nxt.vld = 1'b0;
    end
    // counter and complete bit
    if (|cmplt_vld) begin
      if (n == 4) begin
        nxt.cmplt_cnt = '0;
      end else if (n > 0) begin
        nxt.cmplt_cnt = cnt_width'(int'(base) - n);
      end else begin
        nxt.cmplt_cnt = '0;
      end
      nxt.cmplt = (n > 0 && n < 4 && int'(base) == n) || n == 4 || direct;
    end else if (create_en) begin
      nxt.cmplt_cnt = rec.cmplt_cnt;
      nxt.cmplt     = rec.cmplt;
    end
    return nxt;
  endfunction

  always @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      exp_rec <= '0;
    end else begin
      exp_rec <= next_exp(exp_rec);
    end
  end

  // ==============================
  // checks
  // ==============================
  task automatic report_error(input string field, input logic [rob_width-1:0] exp_val,
                              input logic [rob_width-1:0] act_val);
    err_count++;
    $display("Error %s %s: expected %h, actual %h", test_name, field, exp_val, act_val);
  endtask

  ctl_check: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
      (read_data & ctl_mask) == (exp_rec & ctl_mask))
    else report_error("control", $sampled(exp_rec) & ctl_mask, $sampled(read_data) & ctl_mask);

  wb_check: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
      (read_data & wb_mask) == (exp_rec & wb_mask))
    else report_error("wb_flags", $sampled(exp_rec) & wb_mask, $sampled(read_data) & wb_mask);

  static_check: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
      (read_data & static_mask) == (exp_rec & static_mask))
    else report_error("static", $sampled(exp_rec) & static_mask,
                      $sampled(read_data) & static_mask);

  // ==============================
  // stimulus helpers
  // ==============================
  task automatic idle_inputs();
    create_en    = 1'b0;
    create_dp_en = 1'b0;
    pop_en       = 1'b0;
    flush        = 1'b0;
    cmplt_vld    = '0;
  endtask

  // random records in every slot with one of them selected
  task automatic create_cycle(input bit force_vld);
    int slot;
    @(negedge entry_clk);
    idle_inputs();
    for (int i = 0; i < create_ports; i++) begin
      create_data[i]    = rob_width'({lcg_next(), lcg_next()});
      create_data[i][0] = create_data[i][0] | force_vld;
    end
    slot         = int'((lcg_next() >> 8) % create_ports);
    create_sel   = create_ports'(1) << slot;
    create_en    = 1'b1;
    create_dp_en = 1'b1;
  endtask

  // every fourth pattern has all fold ports
  function automatic logic [cmplt_ports-1:0] fold_pattern(input int k);
    logic [cmplt_ports-1:0] v;
    logic [31:0]            r;
    r          = lcg_next() >> 20;
    v          = '0;
    v[fold_p0] = r[0] | (k % 4 == 0);
    v[fold_p1] = r[1] | (k % 4 == 0);
    v[fold_p5] = r[2] | (k % 4 == 0);
    v[fold_p6] = r[3] | (k % 4 == 0);
    return v;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  // two more edges so the last update is checked
  task automatic end_test();
    repeat (2) @(negedge entry_clk);
    if (err_count == test_errs) begin
      pass_count++;
      $display("test %s: pass", test_name);
    end else begin
      fail_count++;
      $display("test %s: fail, %0d errors", test_name, err_count - test_errs);
    end
  endtask

  // ==============================
  // tests
  // ==============================
  initial begin
    cpurst_b   = 1'b0;
    create_sel = create_ports'(1);
    p3_flags   = '0;
    p4_flags   = '0;
    idle_inputs();
    for (int i = 0; i < create_ports; i++) begin
      create_data[i] = '0;
    end
    start_test("reset");
    repeat (3) @(posedge entry_clk);
    @(negedge entry_clk);
    cpurst_b = 1'b1;
    end_test();

    start_test("create_readback");
    for (int i = 0; i < create_iters; i++) begin
      create_cycle(1'b0);
      @(negedge entry_clk);
      idle_inputs();
    end
    end_test();

    start_test("folded_completion");
    for (int i = 0; i < fold_iters; i++) begin
      create_cycle(1'b1);
      // odd rounds also complete in the create cycle
      if (i % 2 == 1) begin
        cmplt_vld = fold_pattern(i);
      end
      @(negedge entry_clk);
      idle_inputs();
      cmplt_vld = fold_pattern(i + 1);
      @(negedge entry_clk);
      idle_inputs();
    end
    end_test();

    start_test("direct_lsu_completion");
    for (int i = 0; i < direct_iters; i++) begin
      create_cycle(1'b1);
      @(negedge entry_clk);
      idle_inputs();
      // nonzero mix of ports 2 to 4
      cmplt_vld = cmplt_ports'(((lcg_next() >> 12) % 7 + 1) << direct_p2);
      p3_flags  = 5'(lcg_next() >> 16);
      p4_flags  = 5'(lcg_next() >> 16);
      @(negedge entry_clk);
      idle_inputs();
    end
    end_test();

    start_test("flush_pop");
    create_cycle(1'b1);
    // flush in the same cycle as create
    create_cycle(1'b1);
    flush = 1'b1;
    create_cycle(1'b1);
    // create beats pop
    create_cycle(1'b1);
    pop_en = 1'b1;
    @(negedge entry_clk);
    idle_inputs();
    pop_en = 1'b1;
    @(negedge entry_clk);
    idle_inputs();
    end_test();

    $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog at twice the expected run length
  initial begin
    #(2 * run_cycles * 4);
    $display("watchdog: run did not finish within %0d ns", 2 * run_cycles * 4);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- source/rob_entry.sv
`timescale 1ns/100ps

module rob_entry (
  input  logic                                  entry_clk,
  input  logic                                  cpurst_b,
  input  logic [rob_entry_pkg::rob_width-1:0]   create0_data,
  input  logic [rob_entry_pkg::rob_width-1:0]   create1_data,
  input  logic [rob_entry_pkg::rob_width-1:0]   create2_data,
  input  logic [rob_entry_pkg::rob_width-1:0]   create3_data,
  input  logic [rob_entry_pkg::rob_width-1:0]   create4_data,
  input  logic [rob_entry_pkg::create_ports-1:0] create_sel,
  input  logic                                  create_en,
  input  logic                                  create_dp_en,
  input  logic                                  pop_en,
  input  logic                                  flush,
  input  logic [rob_entry_pkg::cmplt_ports-1:0] cmplt_vld,
  input  logic                                  pipe3_bkpta_data,
  input  logic                                  pipe3_bkptb_data,
  input  logic                                  pipe3_no_spec_hit,
  input  logic                                  pipe3_no_spec_miss,
  input  logic                                  pipe3_no_spec_mispred,
  input  logic                                  pipe4_bkpta_data,
  input  logic                                  pipe4_bkptb_data,
  input  logic                                  pipe4_no_spec_hit,
  input  logic                                  pipe4_no_spec_miss,
  input  logic                                  pipe4_no_spec_mispred,
  output logic [rob_entry_pkg::rob_width-1:0]   read_data
);

  import rob_entry_pkg::*;

  rob_entry_t [create_ports-1:0] create_data;
  rob_entry_t                    create_rec;
  rob_entry_t                    inst_info;
  rob_entry_t                    read_rec;
  lsu_wb_info_t                  pipe3_info;
  lsu_wb_info_t                  pipe4_info;
  lsu_wb_info_t                  wb_info;
  logic                          vld;
  logic                          cmplt;
  logic [cnt_width-1:0]          cmplt_cnt;

  // ==============================
  // input packing
  // ==============================
  // slot 0 in the low record
  assign create_data = {create4_data, create3_data, create2_data, create1_data, create0_data};

  assign pipe3_info = {pipe3_bkpta_data, pipe3_bkptb_data, pipe3_no_spec_hit,
                       pipe3_no_spec_miss, pipe3_no_spec_mispred};
  assign pipe4_info = {pipe4_bkpta_data, pipe4_bkptb_data, pipe4_no_spec_hit,
                       pipe4_no_spec_miss, pipe4_no_spec_mispred};

  // ==============================
  // entry blocks
  // ==============================
  rob_create_port u_create_port (
    .entry_clk    (entry_clk),
    .cpurst_b     (cpurst_b),
    .create_data  (create_data),
    .create_sel   (create_sel),
    .create_dp_en (create_dp_en),
    .create_rec   (create_rec),
    .inst_info    (inst_info)
  );

  rob_cmplt_ctrl u_cmplt_ctrl (
    .entry_clk  (entry_clk),
    .cpurst_b   (cpurst_b),
    .create_rec (create_rec),
    .create_en  (create_en),
    .pop_en     (pop_en),
    .flush      (flush),
    .cmplt_vld  (cmplt_vld),
    .vld        (vld),
    .cmplt      (cmplt),
    .cmplt_cnt  (cmplt_cnt)
  );

  rob_lsu_wb_info u_lsu_wb_info (
    .entry_clk    (entry_clk),
    .cpurst_b     (cpurst_b),
    .create_rec   (create_rec),
    .create_dp_en (create_dp_en),
    .cmplt_vld    (cmplt_vld),
    .pipe3_info   (pipe3_info),
    .pipe4_info   (pipe4_info),
    .wb_info      (wb_info)
  );

  // ==============================
  // read record
  // ==============================
  // static fields from create, then write-back and control on top
  always_comb begin
    read_rec                 = inst_info;
    read_rec.bkpta_data      = wb_info.bkpta_data;
    read_rec.bkptb_data      = wb_info.bkptb_data;
    read_rec.no_spec_hit     = wb_info.no_spec_hit;
    read_rec.no_spec_miss    = wb_info.no_spec_miss;
    read_rec.no_spec_mispred = wb_info.no_spec_mispred;
    read_rec.cmplt_cnt       = cmplt_cnt;
    read_rec.cmplt           = cmplt;
    read_rec.vld             = vld;
  end

  assign read_data = read_rec;

endmodule

//--- source/rob_lsu_wb_info.sv
`timescale 1ns/100ps

module rob_lsu_wb_info (
  input  logic                                  entry_clk,
  input  logic                                  cpurst_b,
  input  rob_entry_pkg::rob_entry_t             create_rec,
  input  logic                                  create_dp_en,
  input  logic [rob_entry_pkg::cmplt_ports-1:0] cmplt_vld,
  input  rob_entry_pkg::lsu_wb_info_t           pipe3_info,
  input  rob_entry_pkg::lsu_wb_info_t           pipe4_info,
  output rob_entry_pkg::lsu_wb_info_t           wb_info
);

  import rob_entry_pkg::*;

  logic         lsu_cmplt;
  lsu_wb_info_t wb_updt;
  lsu_wb_info_t wb_create;

  // ==============================
  // write-back merge
  // ==============================
  // only pipes 3 and 4 carry data breakpoints
  assign lsu_cmplt = cmplt_vld[lsu_p3] | cmplt_vld[lsu_p4];

  // each pipe gated by its own completion strobe
  assign wb_updt = ({$bits(lsu_wb_info_t){cmplt_vld[lsu_p3]}} & pipe3_info)
                 | ({$bits(lsu_wb_info_t){cmplt_vld[lsu_p4]}} & pipe4_info);

  // initial flags from decode
  assign wb_create = '{
    bkpta_data:      create_rec.bkpta_data,
    bkptb_data:      create_rec.bkptb_data,
    no_spec_hit:     create_rec.no_spec_hit,
    no_spec_miss:    create_rec.no_spec_miss,
    no_spec_mispred: create_rec.no_spec_mispred
  };

  // ==============================
  // flag register
  // ==============================
  // lsu write-back beats create
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_info <= '0;
    end else if (lsu_cmplt) begin
      wb_info <= wb_updt;
    end else if (create_dp_en) begin
      wb_info <= wb_create;
    end
  end

endmodule

//--- source/rob_cmplt_ctrl.sv
`timescale 1ns/100ps

module rob_cmplt_ctrl (
  input  logic                                   entry_clk,
  input  logic                                   cpurst_b,
  input  rob_entry_pkg::rob_entry_t              create_rec,
  input  logic                                   create_en,
  input  logic                                   pop_en,
  input  logic                                   flush,
  input  logic [rob_entry_pkg::cmplt_ports-1:0]  cmplt_vld,
  output logic                                   vld,
  output logic                                   cmplt,
  output logic [rob_entry_pkg::cnt_width-1:0]    cmplt_cnt
);

  import rob_entry_pkg::*;

  logic [fold_ports-1:0] fold_vld;
  logic [cnt_width:0]    fold_num;
  logic                  any_cmplt;
  logic                  direct_cmplt;
  logic                  fold_some;
  logic                  fold_all;
  logic [cnt_width-1:0]  cnt_base;
  logic [cnt_width-1:0]  cnt_updt;
  logic                  cmplt_updt;

  // ==============================
  // entry valid
  // ==============================
  // flush beats create, create beats pop
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      vld <= 1'b0;
    end else if (flush) begin
      vld <= 1'b0;
    end else if (create_en) begin
      vld <= create_rec.vld;
    end else if (pop_en) begin
      vld <= 1'b0;
    end
  end

  // ==============================
  // completion decode
  // ==============================
  assign fold_vld = {cmplt_vld[fold_p6], cmplt_vld[fold_p5],
                     cmplt_vld[fold_p1], cmplt_vld[fold_p0]};

  // number of folded insts retiring this cycle
  always_comb begin
    fold_num = '0;
    foreach (fold_vld[i]) begin
      fold_num = fold_num + {{cnt_width{1'b0}}, fold_vld[i]};
    end
  end

  assign any_cmplt    = |cmplt_vld;
  // bju and both lsu pipes finish the entry outright
  assign direct_cmplt = cmplt_vld[direct_p2] | cmplt_vld[lsu_p3] | cmplt_vld[lsu_p4];
  assign fold_all     = (fold_num == fold_ports);
  assign fold_some    = (fold_num != '0) && !fold_all;

  // count seen by completion, create count if created this cycle
  assign cnt_base = create_en ? create_rec.cmplt_cnt : cmplt_cnt;

  always_comb begin
    if (fold_all) begin
      cnt_updt = '0;
    end else if (fold_some) begin
      // wraps modulo counter width
      cnt_updt = cnt_base - fold_num[cnt_width-1:0];
    end else if (direct_cmplt) begin
      cnt_updt = '0;
    end else begin
      cnt_updt = cnt_base;
    end
  end

  // done once the last folded inst retires
  assign cmplt_updt = (fold_some && (cnt_base == fold_num[cnt_width-1:0]))
                   || fold_all
                   || direct_cmplt;

  // ==============================
  // counter and complete bit
  // ==============================
  // completion beats create
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cmplt_cnt <= '0;
      cmplt     <= 1'b0;
    end else if (any_cmplt) begin
      cmplt_cnt <= cnt_updt;
      cmplt     <= cmplt_updt;
    end else if (create_en) begin
      cmplt_cnt <= create_rec.cmplt_cnt;
      cmplt     <= create_rec.cmplt;
    end
  end

endmodule

//--- source/rob_create_port.sv
`timescale 1ns/100ps

module rob_create_port (
  input  logic                                                  entry_clk,
  input  logic                                                  cpurst_b,
  input  rob_entry_pkg::rob_entry_t [rob_entry_pkg::create_ports-1:0] create_data,
  input  logic [rob_entry_pkg::create_ports-1:0]                create_sel,
  input  logic                                                  create_dp_en,
  output rob_entry_pkg::rob_entry_t                             create_rec,
  output rob_entry_pkg::rob_entry_t                             inst_info
);

  import rob_entry_pkg::*;

  // create-only fields, other bits held at zero
  rob_entry_t inst_next;

  // ==============================
  // create record select
  // ==============================
  // one-hot select, x on anything else
  always_comb begin
    create_rec = 'x;
    for (int i = 0; i < create_ports; i++) begin
      if (create_sel == (create_ports'(1) << i)) begin
        create_rec = create_data[i];
      end
    end
  end

  // ==============================
  // create-only inst info
  // ==============================
  always_comb begin
    inst_next            = '0;
    // pc and flow control
    inst_next.pc_offset  = create_rec.pc_offset;
    inst_next.split      = create_rec.split;
    inst_next.intmask    = create_rec.intmask;
    inst_next.bju        = create_rec.bju;
    inst_next.pcfifo     = create_rec.pcfifo;
    inst_next.ras        = create_rec.ras;
    // memory and debug
    inst_next.store      = create_rec.store;
    inst_next.load       = create_rec.load;
    inst_next.bkpta_inst = create_rec.bkpta_inst;
    inst_next.bkptb_inst = create_rec.bkptb_inst;
    inst_next.inst_num   = create_rec.inst_num;
    inst_next.fp_dirty   = create_rec.fp_dirty;
    // vector config
    inst_next.vlmul      = create_rec.vlmul;
    inst_next.vsew       = create_rec.vsew;
    inst_next.vsetvli    = create_rec.vsetvli;
    inst_next.vec_dirty  = create_rec.vec_dirty;
    inst_next.vl         = create_rec.vl;
    inst_next.vl_pred    = create_rec.vl_pred;
  end

  // loaded on datapath create, held otherwise
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      inst_info <= '0;
    end else if (create_dp_en) begin
      inst_info <= inst_next;
    end
  end

endmodule

//--- source/rob_entry_pkg.sv
package rob_entry_pkg;

  // ==============================
  // entry geometry
  // ==============================
  // full entry record width
  localparam int rob_width   = 40;
  // create sources from decode
  localparam int create_ports = 5;
  // completion ports into the entry
  localparam int cmplt_ports  = 7;
  // folded instruction counter
  localparam int cnt_width    = 2;
  // ports that retire one folded inst each
  localparam int fold_ports   = 4;

  // ==============================
  // entry record, msb first
  // ==============================
  typedef struct packed {
    logic                 vl_pred;
    logic [7:0]           vl;
    logic                 vec_dirty;
    logic                 vsetvli;
    logic [2:0]           vsew;
    logic [1:0]           vlmul;
    logic                 no_spec_mispred;
    logic                 no_spec_miss;
    logic                 no_spec_hit;
    logic                 load;
    logic                 fp_dirty;
    logic [1:0]           inst_num;
    logic                 bkptb_inst;
    logic                 bkpta_inst;
    logic                 bkptb_data;
    logic                 bkpta_data;
    logic                 store;
    logic                 ras;
    logic                 pcfifo;
    logic                 bju;
    logic                 intmask;
    logic                 split;
    logic [2:0]           pc_offset;
    logic [cnt_width-1:0] cmplt_cnt;
    logic                 cmplt;
    logic                 vld;
  } rob_entry_t;

  // load/store write-back flags, one set per pipe
  typedef struct packed {
    logic bkpta_data;
    logic bkptb_data;
    logic no_spec_hit;
    logic no_spec_miss;
    logic no_spec_mispred;
  } lsu_wb_info_t;

  // completion port index
  typedef enum logic [2:0] {
    fold_p0   = 3'd0,
    fold_p1   = 3'd1,
    direct_p2 = 3'd2,
    lsu_p3    = 3'd3,
    lsu_p4    = 3'd4,
    fold_p5   = 3'd5,
    fold_p6   = 3'd6
  } cmplt_port_e;

endpackage
